// File: source/burst_pkg.sv
//--------------------------------------
// Addresses count 32-bit words, not bytes
// Burst counts are in beats and must never be zero
// Source and sink share one request layout
//--------------------------------------
package burst_pkg;

    // Word address and data sizes
    localparam int ADDR_WIDTH = 10;
    localparam int DATA_WIDTH = 32;
    localparam int DATA_N_BYTES = DATA_WIDTH / 8;

    // Every burstcount field is this wide so counts 1 to 16 fit
    localparam int MAX_BURST_WIDTH = 5;

    // User flags travel with each request beat
    localparam int USER_WIDTH = 1;
    // Set on extra sink write bursts whose responses must be dropped
    localparam int UFLAG_NO_REPLY = 0;

    // One request beat in Avalon order
    // Address and burstcount only matter on the first beat of a burst
    typedef struct packed {
        logic                       read;
        logic                       write;
        logic [ADDR_WIDTH-1:0]      address;
        logic [MAX_BURST_WIDTH-1:0] burstcount;
        logic [DATA_WIDTH-1:0]      writedata;
        logic [DATA_N_BYTES-1:0]    byteenable;
        logic [USER_WIDTH-1:0]      user;
    } mem_req_t;

    // Responses have no back-pressure
    typedef struct packed {
        logic                  readdatavalid;
        logic [DATA_WIDTH-1:0] readdata;
        logic                  writeresponsevalid;
        logic [USER_WIDTH-1:0] writeresponseuser;
    } mem_rsp_t;

endpackage

// File: source/sop_tracker.sv
`timescale 1ns/100ps
//--------------------------------------
// Counts beats only while flit_valid is high
// burstcount is sampled on the first beat only
//--------------------------------------
module sop_tracker
#(
    parameter int BURST_CNT_WIDTH = 5
)
(
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       flit_valid,
    input  logic [BURST_CNT_WIDTH-1:0] burstcount,
    output logic                       sop
);

    // Beats still owed to the burst in flight
    logic [BURST_CNT_WIDTH-1:0] beats_left;

    // Nothing owed means the next valid beat opens a new burst
    assign sop = (beats_left == '0);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            beats_left <= '0;
        end
        else if (flit_valid)
        begin
            // The first beat itself is consumed here
            if (sop)
                beats_left <= burstcount - 1'b1;
            else
                beats_left <= beats_left - 1'b1;
        end
    end

    // A zero count at the first beat would wrap the counter to its maximum
    a_sop_count_nonzero: assert property (@(posedge clk) disable iff (!reset_n)
        (flit_valid && sop) |-> (burstcount != '0))
        else $error("%m: start of packet beat with zero burstcount");

endmodule

// File: source/burst_gearbox.sv
`timescale 1ns/100ps
//--------------------------------------
// Sink bursts are at most 2**(SINK_BURST_WIDTH-1) beats
// With NATURAL_ALIGNMENT set each piece starts on a multiple
// of the largest power of two not above its length
//--------------------------------------
module burst_gearbox
#(
    parameter int SOURCE_BURST_WIDTH = 5,
    parameter int SINK_BURST_WIDTH = 3,
    parameter int NATURAL_ALIGNMENT = 1
)
(
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            new_req,
    input  logic [burst_pkg::ADDR_WIDTH-1:0] source_addr,
    input  logic [SOURCE_BURST_WIDTH-1:0]   source_burstcount,
    input  logic                            accept_req,
    output logic                            req_complete,
    output logic [burst_pkg::ADDR_WIDTH-1:0] sink_addr,
    output logic [SINK_BURST_WIDTH-1:0]     sink_burstcount
);

    localparam int AW = burst_pkg::ADDR_WIDTH;

    // Largest legal sink burst held at source width for comparisons
    localparam logic [SOURCE_BURST_WIDTH-1:0] SINK_MAX =
        SOURCE_BURST_WIDTH'(1) << (SINK_BURST_WIDTH - 1);

    // Address and beats left of the current source burst
    logic [AW-1:0]                 cur_addr;
    logic [SOURCE_BURST_WIDTH-1:0] remaining;
    // Size limit from address alignment
    logic [SOURCE_BURST_WIDTH-1:0] align_cap;
    // Length of the piece now on offer to the sink
    logic [SOURCE_BURST_WIDTH-1:0] piece;

    always_comb
    begin
        // Walk from the high bit down so the lowest set address bit wins
        align_cap = SINK_MAX;
        if (NATURAL_ALIGNMENT != 0)
        begin
            for (int i = SINK_BURST_WIDTH - 2; i >= 0; i--)
            begin
                if (cur_addr[i])
                    align_cap = SOURCE_BURST_WIDTH'(1) << i;
            end
        end

        // Smallest of beats left, sink maximum and alignment limit
        piece = remaining;
        if (piece > SINK_MAX)
            piece = SINK_MAX;
        if (piece > align_cap)
            piece = align_cap;
    end

    // The piece that covers every remaining beat is the last one
    assign req_complete = (remaining == piece);
    assign sink_addr = cur_addr;
    assign sink_burstcount = piece[SINK_BURST_WIDTH-1:0];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            cur_addr <= '0;
            remaining <= '0;
        end
        else if (new_req)
        begin
            // A fresh source burst replaces whatever piece was just taken
            cur_addr <= source_addr;
            remaining <= source_burstcount;
        end
        else if (accept_req)
        begin
            cur_addr <= cur_addr + AW'(piece);
            remaining <= remaining - piece;
        end
    end

    // A piece is only taken while beats of the source burst remain
    a_piece_nonzero: assert property (@(posedge clk) disable iff (!reset_n)
        accept_req |-> (piece != '0))
        else $error("%m: sink piece taken with no beats left in the source burst");

endmodule

// File: source/burst_mapper.sv
`timescale 1ns/100ps
//--------------------------------------
// The sink must echo first-beat user bits in writeresponseuser
// Requires SINK_BURST_WIDTH < SOURCE_BURST_WIDTH <= MAX_BURST_WIDTH
// Read and write responses are never back-pressured
//--------------------------------------
module burst_mapper
#(
    parameter int SOURCE_BURST_WIDTH = 5,
    parameter int SINK_BURST_WIDTH = 3,
    parameter int NATURAL_ALIGNMENT = 1
)
(
    input  logic                clk,
    input  logic                reset_n,
    input  burst_pkg::mem_req_t src_req,
    output logic                src_waitrequest,
    output burst_pkg::mem_rsp_t src_rsp,
    output burst_pkg::mem_req_t sink_req,
    input  logic                sink_waitrequest,
    input  burst_pkg::mem_rsp_t sink_rsp
);

    logic                                req_complete;
    logic                                new_req;
    logic                                accept_req;
    logic                                src_wr_sop;
    logic                                sink_wr_sop;
    logic [burst_pkg::ADDR_WIDTH-1:0]    gb_addr;
    logic [SINK_BURST_WIDTH-1:0]         gb_burstcount;
    logic                                sink_read;
    logic                                sink_write;
    logic [burst_pkg::DATA_WIDTH-1:0]    sink_wdata;
    logic [burst_pkg::DATA_N_BYTES-1:0]  sink_be;
    logic [31:0]                         src_wr_bursts;
    logic [31:0]                         src_wr_rsps;

    if (SOURCE_BURST_WIDTH > burst_pkg::MAX_BURST_WIDTH ||
        SINK_BURST_WIDTH >= SOURCE_BURST_WIDTH)
    begin : g_bad_widths
        $error("%m: illegal SOURCE_BURST_WIDTH / SINK_BURST_WIDTH pair");
    end

    // Hold the source while the sink stalls or a read still has pieces to issue
    // Writes need no extra stall since the beat count is the same on both sides
    assign src_waitrequest = sink_waitrequest || (sink_read && !req_complete);

    // Source reads and first write beats open a new burst in the gearbox
    assign new_req = !src_waitrequest && src_wr_sop;

    // A sink piece is taken on its first beat
    assign accept_req = !sink_waitrequest && sink_wr_sop && (sink_read || sink_write);

    burst_gearbox #(
        .SOURCE_BURST_WIDTH(SOURCE_BURST_WIDTH),
        .SINK_BURST_WIDTH(SINK_BURST_WIDTH),
        .NATURAL_ALIGNMENT(NATURAL_ALIGNMENT)
    ) gearbox (
        .clk,
        .reset_n,
        .new_req,
        .source_addr(src_req.address),
        .source_burstcount(src_req.burstcount[SOURCE_BURST_WIDTH-1:0]),
        .accept_req,
        .req_complete,
        .sink_addr(gb_addr),
        .sink_burstcount(gb_burstcount)
    );

    // First write beats on the source side
    sop_tracker #(.BURST_CNT_WIDTH(SOURCE_BURST_WIDTH)) src_sop (
        .clk,
        .reset_n,
        .flit_valid(src_req.write && !src_waitrequest),
        .burstcount(src_req.burstcount[SOURCE_BURST_WIDTH-1:0]),
        .sop(src_wr_sop)
    );

    // First write beats of each sink piece
    sop_tracker #(.BURST_CNT_WIDTH(SINK_BURST_WIDTH)) sink_sop (
        .clk,
        .reset_n,
        .flit_valid(sink_write && !sink_waitrequest),
        .burstcount(gb_burstcount),
        .sop(sink_wr_sop)
    );

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            sink_read <= 1'b0;
            sink_write <= 1'b0;
        end
        else if (!src_waitrequest)
        begin
            sink_read <= src_req.read;
            sink_write <= src_req.write;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!src_waitrequest)
        begin
            sink_wdata <= src_req.writedata;
            sink_be <= src_req.byteenable;
        end
    end

    always_comb
    begin
        sink_req = '0;
        sink_req.read = sink_read;
        sink_req.write = sink_write;
        sink_req.writedata = sink_wdata;
        sink_req.byteenable = sink_be;
        // Address and count only go out on the first beat of a sink piece
        if (sink_wr_sop)
        begin
            sink_req.address = gb_addr;
            sink_req.burstcount[SINK_BURST_WIDTH-1:0] = gb_burstcount;
        end
        // Only the last piece of a source write may answer the initiator
        sink_req.user[burst_pkg::UFLAG_NO_REPLY] = !(req_complete && sink_wr_sop && sink_write);
    end

    // Read data passes straight back and tagged write responses are dropped
    always_comb
    begin
        src_rsp = sink_rsp;
        src_rsp.writeresponsevalid = sink_rsp.writeresponsevalid &&
            !sink_rsp.writeresponseuser[burst_pkg::UFLAG_NO_REPLY];
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            src_wr_bursts <= '0;
            src_wr_rsps <= '0;
        end
        else
        begin
            if (src_req.write && !src_waitrequest && src_wr_sop)
                src_wr_bursts <= src_wr_bursts + 1'b1;
            if (src_rsp.writeresponsevalid)
                src_wr_rsps <= src_wr_rsps + 1'b1;
        end
    end

    // Fires when the sink fails to echo the no-reply flag
    a_rsp_not_ahead: assert property (@(posedge clk) disable iff (!reset_n)
        src_wr_rsps <= src_wr_bursts)
        else $error("%m: more write responses than source write bursts");

endmodule

// File: source/burst_sink_memory.sv
`timescale 1ns/100ps
//--------------------------------------
// Behavioral model only with no memory reset
// Stalls all requests while a read burst streams out
//--------------------------------------
module burst_sink_memory
#(
    parameter int SINK_BURST_WIDTH = 3,
    parameter int NATURAL_ALIGNMENT = 1
)
(
    input  logic                clk,
    input  logic                reset_n,
    input  burst_pkg::mem_req_t sink_req,
    output logic                sink_waitrequest,
    output burst_pkg::mem_rsp_t sink_rsp
);

    localparam int AW = burst_pkg::ADDR_WIDTH;
    localparam logic [burst_pkg::MAX_BURST_WIDTH-1:0] SINK_MAX =
        burst_pkg::MAX_BURST_WIDTH'(1) << (SINK_BURST_WIDTH - 1);

    logic [burst_pkg::DATA_WIDTH-1:0] mem [2**AW];
    logic [SINK_BURST_WIDTH-1:0]      req_count;
    logic [SINK_BURST_WIDTH-1:0]      wr_left;
    logic [SINK_BURST_WIDTH-1:0]      rd_left;
    logic [AW-1:0]                    wr_addr;
    logic [AW-1:0]                    rd_addr;
    logic [AW-1:0]                    wr_beat_addr;
    logic [AW-1:0]                    align_mask;
    logic [burst_pkg::USER_WIDTH-1:0] wr_user;
    logic [burst_pkg::USER_WIDTH-1:0] wr_beat_user;
    logic                             wr_sop;
    logic                             wr_last;
    logic                             wr_fire;
    logic                             rd_fire;
    logic                             rd_valid;
    logic [burst_pkg::DATA_WIDTH-1:0] rd_data;
    logic                             wr_rsp_valid;
    logic [burst_pkg::USER_WIDTH-1:0] wr_rsp_user;

    assign sink_waitrequest = (rd_left != '0);
    assign req_count = sink_req.burstcount[SINK_BURST_WIDTH-1:0];
    assign wr_sop = (wr_left == '0);
    assign wr_fire = sink_req.write && !sink_waitrequest;
    assign rd_fire = sink_req.read && !sink_waitrequest;
    // The first beat brings address and user bits and later beats reuse the saved ones
    assign wr_beat_addr = wr_sop ? sink_req.address : wr_addr;
    assign wr_beat_user = wr_sop ? sink_req.user : wr_user;
    assign wr_last = wr_sop ? (req_count == 1) : (wr_left == 1);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_left <= '0;
            rd_left <= '0;
            rd_valid <= 1'b0;
            wr_rsp_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= (rd_left != '0);
            wr_rsp_valid <= wr_fire && wr_last;
            if (wr_fire)
                wr_left <= wr_sop ? req_count - 1'b1 : wr_left - 1'b1;
            if (rd_fire)
                rd_left <= req_count;
            else if (rd_left != '0)
                rd_left <= rd_left - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_fire)
        begin
            for (int b = 0; b < burst_pkg::DATA_N_BYTES; b++)
            begin
                if (sink_req.byteenable[b])
                    mem[wr_beat_addr][8*b +: 8] <= sink_req.writedata[8*b +: 8];
            end
            wr_addr <= wr_beat_addr + 1'b1;
            wr_user <= wr_beat_user;
        end
        wr_rsp_user <= wr_beat_user;
        // One word per cycle while the read counter runs
        if (rd_fire)
            rd_addr <= sink_req.address;
        else if (rd_left != '0)
            rd_addr <= rd_addr + 1'b1;
        rd_data <= mem[rd_addr];
    end

    always_comb
    begin
        sink_rsp.readdatavalid = rd_valid;
        sink_rsp.readdata = rd_data;
        sink_rsp.writeresponsevalid = wr_rsp_valid;
        sink_rsp.writeresponseuser = wr_rsp_user;
        // Address bits below the top set bit of the count must be clear
        align_mask = '0;
        for (int i = 1; i < SINK_BURST_WIDTH; i++)
        begin
            if (req_count[i])
                align_mask = (AW'(1) << i) - 1'b1;
        end
    end

    // Checks every burst the mapper opens against the sink limits
    a_legal_burst: assert property (@(posedge clk) disable iff (!reset_n)
        ((sink_req.read || (sink_req.write && wr_sop)) && !sink_waitrequest) |->
        (sink_req.burstcount != '0 && sink_req.burstcount <= SINK_MAX &&
         (NATURAL_ALIGNMENT == 0 || (sink_req.address & align_mask) == '0)))
        else $error("%m: illegal sink burst %0d at %0h", sink_req.burstcount,
                    sink_req.address);

endmodule

// File: source/burst_subsystem_top.sv
`timescale 1ns/100ps
//--------------------------------------
// Initiator port only and the memory stays inside
// Source bursts of 1 to 16 beats
//--------------------------------------
module burst_subsystem_top
#(
    parameter int SOURCE_BURST_WIDTH = 5,
    parameter int SINK_BURST_WIDTH = 3,
    parameter int NATURAL_ALIGNMENT = 1
)
(
    input  logic                clk,
    input  logic                reset_n,
    input  burst_pkg::mem_req_t src_req,
    output logic                src_waitrequest,
    output burst_pkg::mem_rsp_t src_rsp
);

    // Legal sink bursts between the mapper and the memory
    burst_pkg::mem_req_t sink_req;
    logic                sink_waitrequest;
    burst_pkg::mem_rsp_t sink_rsp;

    burst_mapper #(
        .SOURCE_BURST_WIDTH(SOURCE_BURST_WIDTH),
        .SINK_BURST_WIDTH(SINK_BURST_WIDTH),
        .NATURAL_ALIGNMENT(NATURAL_ALIGNMENT)
    ) mapper (
        .clk,
        .reset_n,
        .src_req,
        .src_waitrequest,
        .src_rsp,
        .sink_req,
        .sink_waitrequest,
        .sink_rsp
    );

    // The memory enforces the same alignment rule that the mapper obeys
    burst_sink_memory #(
        .SINK_BURST_WIDTH(SINK_BURST_WIDTH),
        .NATURAL_ALIGNMENT(NATURAL_ALIGNMENT)
    ) sink_mem (
        .clk,
        .reset_n,
        .sink_req,
        .sink_waitrequest,
        .sink_rsp
    );

endmodule

// File: sim/burst_tb.sv
`timescale 1ns/100ps
//--------------------------------------
// Words 3 to 138 are filled before any other traffic
// Read data is checked in issue order against a shadow memory
//--------------------------------------
module burst_tb;

    localparam int FILL_BASE = 3;
    localparam int FILL_WORDS = 136;
    localparam int DW = burst_pkg::DATA_WIDTH;
    localparam int NB = burst_pkg::DATA_N_BYTES;

    logic                clk;
    logic                reset_n;
    burst_pkg::mem_req_t src_req;
    logic                src_waitrequest;
    burst_pkg::mem_rsp_t src_rsp;

    // Expected memory contents follow the stimulus in program order
    logic [DW-1:0] shadow [2**burst_pkg::ADDR_WIDTH];
    logic [DW-1:0] exp_q [$];
    logic [DW-1:0] rd_expected;
    integer        seed = 32'h3363;
    int            errors = 0;
    int            cycles = 0;
    int            issued_beats = 0;
    int            wr_bursts = 0;
    int            wr_rsps = 0;
    int            rd_issued = 0;
    int            rd_words = 0;

    burst_subsystem_top #(
        .SOURCE_BURST_WIDTH(5),
        .SINK_BURST_WIDTH(3),
        .NATURAL_ALIGNMENT(1)
    ) UUT (
        .clk,
        .reset_n,
        .src_req,
        .src_waitrequest,
        .src_rsp
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // The limit grows with every beat the stimulus issues
    always @(posedge clk)
    begin
        cycles++;
        if (cycles > 40 * issued_beats + 200)
        begin
            $display("Timeout after %0d cycles with %0d beats issued", cycles, issued_beats);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // Word the memory should hold after a write beat lands on addr
    function automatic logic [DW-1:0] expected_word(input int addr, input logic [DW-1:0] data,
                                                    input logic [NB-1:0] be);
        logic [DW-1:0] word;
        word = shadow[addr];
        for (int b = 0; b < NB; b++)
        begin
            if (be[b])
                word[8*b +: 8] = data[8*b +: 8];
        end
        return word;
    endfunction

    // Every address bit shows up twice in the fill word
    function automatic logic [DW-1:0] fill_word(input int addr);
        logic [9:0] a;
        a = addr[9:0];
        return {a, 6'h15, ~a, 6'h2a};
    endfunction

    // Holds one beat until an edge sees waitrequest low
    task automatic send_beat(input burst_pkg::mem_req_t beat);
        logic accepted;
        src_req = beat;
        accepted = 1'b0;
        while (!accepted)
        begin
            @(negedge clk);
            accepted = !src_waitrequest;
            @(posedge clk);
            #2;
        end
    endtask

    task automatic write_burst(input int addr, input int len, input bit random_data,
                               input bit partial_be);
        burst_pkg::mem_req_t beat;
        beat = '0;
        beat.write = 1'b1;
        beat.address = burst_pkg::ADDR_WIDTH'(addr);
        beat.burstcount = burst_pkg::MAX_BURST_WIDTH'(len);
        wr_bursts++;
        issued_beats += len;
        for (int i = 0; i < len; i++)
        begin
            beat.writedata = random_data ? DW'($random(seed)) : fill_word(addr + i);
            beat.byteenable = partial_be ? NB'($random(seed)) : '1;
            shadow[addr + i] = expected_word(addr + i, beat.writedata, beat.byteenable);
            send_beat(beat);
        end
        src_req = '0;
    endtask

    // Expected words are queued before the request goes out
    task automatic read_burst(input int addr, input int len);
        burst_pkg::mem_req_t beat;
        beat = '0;
        beat.read = 1'b1;
        beat.address = burst_pkg::ADDR_WIDTH'(addr);
        beat.burstcount = burst_pkg::MAX_BURST_WIDTH'(len);
        for (int i = 0; i < len; i++)
            exp_q.push_back(shadow[addr + i]);
        rd_issued += len;
        issued_beats += len;
        send_beat(beat);
        src_req = '0;
    endtask

    // Quiet cycles after the last response catch late extras
    task automatic drain();
        while (exp_q.size() != 0 || wr_rsps != wr_bursts)
            @(posedge clk);
        repeat (20) @(posedge clk);
        #2;
    endtask

    // Responses are stable at the falling edge
    always @(negedge clk)
    begin
        if (reset_n && src_rsp.readdatavalid)
        begin
            rd_words++;
            assert (exp_q.size() != 0)
            else
            begin
                errors++;
                $display("Read data came back at %0t with no read outstanding", $time);
            end
            if (exp_q.size() != 0)
            begin
                rd_expected = exp_q.pop_front();
                assert (src_rsp.readdata === rd_expected)
                else
                begin
                    errors++;
                    $display("error at %0t: src_rsp.readdata = %h, expected %h", $time,
                             src_rsp.readdata, rd_expected);
                end
            end
        end
        if (reset_n && src_rsp.writeresponsevalid)
        begin
            assert (wr_rsps < wr_bursts)
            else
            begin
                errors++;
                $display("Write response at %0t with no write burst waiting for one", $time);
            end
            // A response that reaches the initiator never carries the no-reply flag
            assert (src_rsp.writeresponseuser[burst_pkg::UFLAG_NO_REPLY] === 1'b0)
            else
            begin
                errors++;
                $display("error at %0t: src_rsp.writeresponseuser = %b, expected %b", $time,
                         src_rsp.writeresponseuser, 1'b0);
            end
            wr_rsps++;
        end
    end

    initial
    begin
        int addr;
        int len;
        src_req = '0;
        reset_n = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        reset_n = 1'b1;
        // Idle port, so any response here is flagged by the checker
        repeat (20) @(posedge clk);
        #2;
        // Full-word bursts of every length packed from an odd base
        addr = FILL_BASE;
        for (len = 1; len <= 16; len++)
        begin
            write_burst(addr, len, 1'b0, 1'b0);
            read_burst(addr, len);
            addr += len;
        end
        drain();
        assert (wr_rsps == 16)
        else
        begin
            errors++;
            $display("error at %0t: write responses = %0d, expected %0d", $time, wr_rsps, 16);
        end
        // Partial byte enables merged over the fill pattern
        write_burst(21, 3, 1'b1, 1'b1);
        read_burst(21, 3);
        write_burst(40, 7, 1'b1, 1'b1);
        read_burst(40, 7);
        write_burst(101, 16, 1'b1, 1'b1);
        read_burst(101, 16);
        drain();
        // Random mix with no gap between bursts
        for (int n = 0; n < 60; n++)
        begin
            addr = FILL_BASE + {$random(seed)} % (FILL_WORDS - 15);
            len = 1 + {$random(seed)} % 16;
            if (({$random(seed)} % 2) == 0)
                write_burst(addr, len, 1'b1, 1'b1);
            else
                read_burst(addr, len);
        end
        drain();
        assert (rd_words == rd_issued && wr_rsps == wr_bursts)
        else
        begin
            errors++;
            $display("error at %0t: read words = %0d, expected %0d", $time,
                     rd_words, rd_issued);
            $display("error at %0t: write responses = %0d, expected %0d", $time,
                     wr_rsps, wr_bursts);
        end
        $display("Errors %0d, read words %0d of %0d, write responses %0d of %0d",
                 errors, rd_words, rd_issued, wr_rsps, wr_bursts);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: build.f
source/burst_pkg.sv
source/sop_tracker.sv
source/burst_gearbox.sv
source/burst_mapper.sv
source/burst_sink_memory.sv
source/burst_subsystem_top.sv
sim/burst_tb.sv

// File: Bender.yml
package:
  name: burst_adapter

sources:
  - files:
      - source/burst_pkg.sv
      - source/sop_tracker.sv
      - source/burst_gearbox.sv
      - source/burst_mapper.sv
      - source/burst_sink_memory.sv
      - source/burst_subsystem_top.sv
  - target: simulation
    files:
      - sim/burst_tb.sv
